//--- Bender.yml
package:
  name: bubble_loader

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/loader_cmd_pkg.sv
      - hdl/spi_flash_pkg.sv
      - hdl/load_decode.sv
      - hdl/spi_read_engine.sv
      - hdl/buffer_writer.sv
      - hdl/bubble_loader_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/bubble_loader_checker.sv
      - verif/bubble_loader_tb.sv

//--- bubble_loader_top.f
+incdir+hdl
hdl/loader_cmd_pkg.sv
hdl/spi_flash_pkg.sv
hdl/load_decode.sv
hdl/spi_read_engine.sv
hdl/buffer_writer.sv
hdl/bubble_loader_top.sv
verif/bubble_loader_checker.sv
verif/bubble_loader_tb.sv

//--- hdl/bubble_loader_defs.svh
`ifndef BUBBLE_LOADER_DEFS_SVH
`define BUBBLE_LOADER_DEFS_SVH

// Serial NOR flash READ instruction
`define LOADER_READ_OPCODE 8'h03

// One bubble page in flash
`define LOADER_PAGE_BYTES 128

// Whole bootloader region, spread over four flash pages
`define LOADER_BOOT_BYTES 480

// Bootloader starts right after the last bubble page
`define LOADER_BOOT_PAGE 12'h805

// Highest page a page load may name
`define LOADER_LAST_PAGE 12'h804

// Queue depth, also the credits the host starts with
`define LOADER_CREDITS 2

`endif

//--- hdl/bubble_loader_top.sv
`timescale 1ns/100ps

module bubble_loader_top
(
    input  logic                        master_clock,
    input  logic                        rst_n,
    input  loader_cmd_pkg::load_cmd_t   cmd,
    input  logic [2:0]                  image_number,
    output loader_cmd_pkg::credit_ret_t credit,
    output logic                        spi_cs,
    output logic                        spi_clk,
    output logic                        spi_mosi,
    input  logic                        spi_miso,
    output spi_flash_pkg::buf_write_t   buf_wr
);
    import spi_flash_pkg::*;

    flash_req_t req;
    logic       req_valid;
    logic       req_ready;
    bit_pair_t  pair;
    logic       stream_end;
    logic       load_done;

    load_decode load_decode_inst
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .image_number (image_number),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .load_done    (load_done),
        .credit       (credit)
    );

    spi_read_engine spi_read_engine_inst
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .spi_cs       (spi_cs),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .pair         (pair),
        .stream_end   (stream_end)
    );

    buffer_writer buffer_writer_inst
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .pair         (pair),
        .stream_end   (stream_end),
        .buf_wr       (buf_wr),
        .load_done    (load_done)
    );

endmodule

//--- hdl/buffer_writer.sv
`timescale 1ns/100ps

module buffer_writer
(
    input  logic                      master_clock,
    input  logic                      rst_n,
    input  spi_flash_pkg::bit_pair_t  pair,
    input  logic                      stream_end,
    output spi_flash_pkg::buf_write_t buf_wr,
    output logic                      load_done
);
    logic        strobe;
    logic [10:0] wr_addr;
    logic [1:0]  wr_data;
    logic [10:0] next_addr; // Address of the next pair

    assign buf_wr.strobe = strobe;
    assign buf_wr.addr   = wr_addr;
    assign buf_wr.data   = wr_data;

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            strobe    <= 1'b0;
            load_done <= 1'b0;
            next_addr <= 11'd0;
        end
        else
        begin
            strobe    <= pair.valid;
            load_done <= stream_end; // Last write is already out
            if (stream_end)
            begin
                next_addr <= 11'd0;  // Next load starts at zero
            end
            else if (pair.valid)
            begin
                next_addr <= next_addr + 11'd1;
            end
        end
    end

    always_ff @(posedge master_clock)
    begin
        if (pair.valid)
        begin
            wr_addr <= next_addr;
            wr_data <= pair.bits;
        end
    end

endmodule

//--- hdl/load_decode.sv
`timescale 1ns/100ps
`include "bubble_loader_defs.svh"

module load_decode
(
    input  logic                        master_clock,
    input  logic                        rst_n,
    input  loader_cmd_pkg::load_cmd_t   cmd,
    input  logic [2:0]                  image_number,
    output spi_flash_pkg::flash_req_t   req,
    output logic                        req_valid,
    input  logic                        req_ready,
    input  logic                        load_done,
    output loader_cmd_pkg::credit_ret_t credit
);
    import loader_cmd_pkg::*;
    import spi_flash_pkg::*;

    typedef struct packed
    {
        logic       reject;
        flash_req_t req;
    } queue_entry_t;

    queue_entry_t queue_mem [`LOADER_CREDITS];
    queue_entry_t new_entry;
    logic         wr_ptr;
    logic         rd_ptr;
    logic [1:0]   count;
    logic         head_issued; // Head is with the engine
    logic         is_boot;
    logic [11:0]  flash_page;
    logic         push;
    logic         pop;
    logic         reject_pop;

    assign is_boot    = (cmd.kind == LOAD_BOOT);
    assign flash_page = is_boot ? `LOADER_BOOT_PAGE : cmd.page;

    // Image in 21..19, page in 18..7, offset bits zero
    assign new_entry.reject    = !is_boot && (cmd.page > `LOADER_LAST_PAGE);
    assign new_entry.req.addr  = {2'b00, image_number, flash_page, 7'b000_0000};
    assign new_entry.req.words = is_boot ? 11'(`LOADER_BOOT_BYTES * 4)
                                         : 11'(`LOADER_PAGE_BYTES * 4); // Four words per byte

    assign push       = cmd.valid;
    assign reject_pop = (count != 2'd0) && queue_mem[rd_ptr].reject && !load_done; // Done wins
    assign pop        = load_done || reject_pop;

    assign req       = queue_mem[rd_ptr].req;
    assign req_valid = (count != 2'd0) && !queue_mem[rd_ptr].reject && !head_issued;

    always_ff @(posedge master_clock)
    begin
        if (push)
        begin
            queue_mem[wr_ptr] <= new_entry;
        end
    end

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            count       <= 2'd0;
            head_issued <= 1'b0;
            credit      <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop)
            begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
            if (pop)
            begin
                head_issued <= 1'b0;
            end
            else if (req_valid && req_ready)
            begin
                head_issued <= 1'b1;
            end
            credit.valid <= pop;        // One credit per retired entry
            credit.error <= reject_pop;
        end
    end

endmodule

//--- hdl/loader_cmd_pkg.sv
package loader_cmd_pkg;

    // What a load command fetches
    typedef enum logic
    {
        LOAD_PAGE = 1'b0, // One 128-byte bubble page
        LOAD_BOOT = 1'b1  // The 480-byte bootloader
    } load_kind_t;

    // Host command, valid for a single cycle
    typedef struct packed
    {
        logic       valid;
        load_kind_t kind;
        logic [11:0] page; // Ignored for bootloader loads
    } load_cmd_t;

    // One returned credit per command, oldest first
    typedef struct packed
    {
        logic valid; // Single-cycle pulse
        logic error; // Command was rejected
    } credit_ret_t;

endpackage

//--- hdl/spi_flash_pkg.sv
package spi_flash_pkg;

    // Read request handed to the SPI engine
    typedef struct packed
    {
        logic [23:0] addr;  // Byte address in flash
        logic [10:0] words; // 2-bit buffer words to fill
    } flash_req_t;

    // Two MISO bits, oldest bit in position 1
    typedef struct packed
    {
        logic       valid;
        logic [1:0] bits;
    } bit_pair_t;

    // Write beat towards the bubble buffer RAM
    typedef struct packed
    {
        logic        strobe;
        logic [10:0] addr;
        logic [1:0]  data;
    } buf_write_t;

endpackage

//--- hdl/spi_read_engine.sv
`timescale 1ns/100ps
`include "bubble_loader_defs.svh"

module spi_read_engine
(
    input  logic                      master_clock,
    input  logic                      rst_n,
    input  spi_flash_pkg::flash_req_t req,
    input  logic                      req_valid,
    output logic                      req_ready,
    output logic                      spi_cs,
    output logic                      spi_clk,
    output logic                      spi_mosi,
    input  logic                      spi_miso,
    output spi_flash_pkg::bit_pair_t  pair,
    output logic                      stream_end
);
    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_SETUP,
        ST_CMD,
        ST_DATA,
        ST_END
    } state_t;

    state_t      state;
    logic [5:0]  phase;      // Half-bit counter
    logic [31:0] shift_reg;  // Opcode and address, MSB first
    logic [10:0] words_left;
    logic        first_bit;
    logic        pair_valid;
    logic [1:0]  pair_bits;

    assign req_ready  = (state == ST_IDLE);
    assign spi_mosi   = shift_reg[31];
    assign pair.valid = pair_valid;
    assign pair.bits  = pair_bits;

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= ST_IDLE;
            phase      <= 6'd0;
            spi_cs     <= 1'b1;
            spi_clk    <= 1'b1;
            pair_valid <= 1'b0;
            stream_end <= 1'b0;
        end
        else
        begin
            pair_valid <= 1'b0;
            stream_end <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    spi_cs  <= 1'b1;
                    spi_clk <= 1'b1; // Mode 3 idles high
                    if (req_valid)
                    begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP:
                begin
                    spi_cs <= 1'b0;
                    phase  <= 6'd0;
                    state  <= ST_CMD;
                end
                ST_CMD:
                begin
                    spi_clk <= ~spi_clk;
                    phase   <= phase + 6'd1;
                    if (phase == 6'd63)
                    begin
                        state <= ST_DATA; // Phase wraps to zero
                    end
                end
                ST_DATA:
                begin
                    spi_clk <= ~spi_clk;
                    phase   <= phase + 6'd1;
                    if (phase[1:0] == 2'd3)
                    begin
                        pair_valid <= 1'b1;
                        if (words_left == 11'd1)
                        begin
                            state <= ST_END;
                        end
                    end
                end
                ST_END:
                begin
                    spi_cs     <= 1'b1;
                    stream_end <= 1'b1;
                    state      <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Rising spi_clk falls on odd phases, so MISO is sampled there
    always_ff @(posedge master_clock)
    begin
        case (state)
            ST_IDLE:
            begin
                if (req_valid)
                begin
                    shift_reg  <= {`LOADER_READ_OPCODE, req.addr};
                    words_left <= req.words;
                end
            end
            ST_CMD:
            begin
                if (spi_clk && (phase != 6'd0))
                begin
                    shift_reg <= shift_reg << 1; // Next bit on falling edge
                end
            end
            ST_DATA:
            begin
                if (phase[1:0] == 2'd1)
                begin
                    first_bit <= spi_miso;
                end
                if (phase[1:0] == 2'd3)
                begin
                    pair_bits  <= {first_bit, spi_miso};
                    words_left <= words_left - 11'd1;
                end
            end
            default:
            begin
                first_bit <= first_bit;
            end
        endcase
    end

endmodule

//--- verif/bubble_loader_checker.sv
`timescale 1ns/100ps
`include "bubble_loader_defs.svh"

module bubble_loader_checker
(
    input logic                        master_clock,
    input logic                        rst_n,
    input loader_cmd_pkg::load_cmd_t   cmd,
    input logic [2:0]                  image_number,
    input loader_cmd_pkg::credit_ret_t credit,
    input logic                        spi_cs,
    input logic                        spi_clk,
    input logic                        spi_mosi,
    input spi_flash_pkg::buf_write_t   buf_wr
);
    import loader_cmd_pkg::*;

    logic [23:0] load_addr_q [$];  // Accepted loads, oldest first
    int          load_words_q [$];
    bit          credit_err_q [$]; // Expected error flag per command
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          commands_seen   = 0;
    int          words_checked   = 0;
    int          loads_finished  = 0; // Fully written, credit still due
    int          mosi_count      = 0;
    logic [31:0] mosi_word;
    bit          load_active     = 1'b0;
    int          word_idx        = 0;
    logic        prev_cs         = 1'b1;
    logic        prev_clk        = 1'b1;
    bit          idle_reported   = 1'b0;

    function automatic logic [23:0] flash_address(input logic [2:0]  image,
                                                  input logic [11:0] page);
        return {2'b00, image, page, 7'b000_0000};
    endfunction

    // Byte value is the XOR of its address bytes, split MSB first into 2-bit words
    function automatic logic [1:0] flash_word(input logic [23:0] base, input int idx);
        logic [23:0] addr;
        logic [7:0]  data_byte;
        addr      = base + 24'(idx / 4);
        data_byte = addr[23:16] ^ addr[15:8] ^ addr[7:0];
        return data_byte[7 - 2 * (idx % 4) -: 2];
    endfunction

    always @(negedge master_clock)
    begin : watch_ports
        bit         reject;
        bit         expected_err;
        logic [1:0] expected_data;
        if (rst_n === 1'b1 && commands_seen == 0 && !idle_reported &&
            (spi_cs !== 1'b1 || spi_clk !== 1'b1))
        begin
            $display("** Error: spi_cs = 0x%h spi_clk = 0x%h, expected 0x1 0x1 after reset",
                     spi_cs, spi_clk);
            value_errors++;
            idle_reported = 1'b1;
        end
        if (rst_n && cmd.valid === 1'b1)
        begin
            if (credit_err_q.size() >= `LOADER_CREDITS)
            begin
                $display("Host sent a command while holding no credit");
                protocol_errors++;
            end
            reject = (cmd.kind == LOAD_PAGE) && (cmd.page > `LOADER_LAST_PAGE);
            credit_err_q.push_back(reject);
            if (!reject && cmd.kind == LOAD_BOOT)
            begin
                load_addr_q.push_back(flash_address(image_number, `LOADER_BOOT_PAGE));
                load_words_q.push_back(`LOADER_BOOT_BYTES * 4);
            end
            else if (!reject)
            begin
                load_addr_q.push_back(flash_address(image_number, cmd.page));
                load_words_q.push_back(`LOADER_PAGE_BYTES * 4);
            end
            commands_seen++;
        end
        if (prev_cs === 1'b1 && spi_cs === 1'b0)
        begin
            mosi_count = 0;
            if (load_addr_q.size() == 0 || load_active)
            begin
                $display("Flash chip select went low with no accepted load waiting");
                protocol_errors++;
            end
        end
        if (spi_cs === 1'b0 && prev_clk === 1'b0 && spi_clk === 1'b1 && mosi_count < 32)
        begin
            mosi_word = {mosi_word[30:0], spi_mosi}; // Rising spi_clk, flash samples here
            mosi_count++;
            if (mosi_count == 32 && load_addr_q.size() != 0)
            begin
                if (mosi_word !== {`LOADER_READ_OPCODE, load_addr_q[0]})
                begin
                    $display("** Error: spi_mosi instruction = 0x%h, expected 0x%h",
                             mosi_word, {`LOADER_READ_OPCODE, load_addr_q[0]});
                    value_errors++;
                end
                load_active = 1'b1;
                word_idx    = 0;
            end
        end
        prev_cs  = spi_cs;
        prev_clk = spi_clk;
        if (rst_n === 1'b1 && buf_wr.strobe !== 1'b0)
        begin
            if (!load_active)
            begin
                $display("Buffer write at address 0x%h with no load in progress", buf_wr.addr);
                protocol_errors++;
            end
            else
            begin
                expected_data = flash_word(load_addr_q[0], word_idx);
                if (buf_wr.addr !== 11'(word_idx))
                begin
                    $display("** Error: buf_wr.addr = 0x%h, expected 0x%h",
                             buf_wr.addr, 11'(word_idx));
                    value_errors++;
                end
                if (buf_wr.data !== expected_data)
                begin
                    $display("** Error: buf_wr.data = 0x%h, expected 0x%h (word 0x%h)",
                             buf_wr.data, expected_data, 11'(word_idx));
                    value_errors++;
                end
                word_idx++;
                words_checked++;
                if (word_idx == load_words_q[0])
                begin
                    load_addr_q.pop_front();
                    load_words_q.pop_front();
                    load_active = 1'b0;
                    loads_finished++;
                end
            end
        end
        if (rst_n === 1'b1 && credit.valid !== 1'b0)
        begin
            if (credit_err_q.size() == 0)
            begin
                $display("Credit returned with no command outstanding");
                protocol_errors++;
            end
            else
            begin
                expected_err = credit_err_q.pop_front();
                if (credit.error !== expected_err)
                begin
                    $display("** Error: credit.error = 0x%h, expected 0x%h",
                             credit.error, expected_err);
                    value_errors++;
                end
                if (!expected_err && loads_finished == 0)
                begin
                    $display("Done credit returned before its load finished writing");
                    protocol_errors++;
                end
                else if (!expected_err)
                begin
                    loads_finished--;
                end
            end
        end
    end

    task automatic finish_checks(output int total_errors);
        if (credit_err_q.size() != 0)
        begin
            $display("%0d commands never returned a credit", credit_err_q.size());
            protocol_errors++;
        end
        if (load_addr_q.size() != 0)
        begin
            $display("%0d accepted loads never finished writing the buffer", load_addr_q.size());
            protocol_errors++;
        end
        $display("Checker: %0d commands, %0d buffer words, %0d value errors, %0d protocol errors",
                 commands_seen, words_checked, value_errors, protocol_errors);
        total_errors = value_errors + protocol_errors;
    endtask

endmodule

//--- verif/bubble_loader_tb.sv
`timescale 1ns/100ps
`include "bubble_loader_defs.svh"

module bubble_loader_tb;
    import loader_cmd_pkg::*;
    import spi_flash_pkg::*;

    localparam int NUM_COMMANDS = 24;
    localparam int WAIT_LIMIT   = 40000; // Cycles, two bootloader loads fit easily

    logic        master_clock;
    logic        rst_n;
    load_cmd_t   cmd;
    logic [2:0]  image_number;
    credit_ret_t credit;
    logic        spi_cs;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_miso;
    buf_write_t  buf_wr;

    integer      seed;
    int          issued     = 0;
    int          returned   = 0;
    bit          timed_out  = 1'b0;
    int          error_count;
    logic [31:0] flash_instr;
    int          flash_bits = 0; // Bits exchanged since chip select fell

    bubble_loader_top bubble_loader_top_inst
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .image_number (image_number),
        .credit       (credit),
        .spi_cs       (spi_cs),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .buf_wr       (buf_wr)
    );

    bubble_loader_checker bubble_loader_checker_inst
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .image_number (image_number),
        .credit       (credit),
        .spi_cs       (spi_cs),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .buf_wr       (buf_wr)
    );

    initial master_clock = 1'b0;
    always #50 master_clock = ~master_clock;

    function automatic logic [7:0] flash_byte(input logic [23:0] addr);
        return addr[23:16] ^ addr[15:8] ^ addr[7:0];
    endfunction

    always @(negedge spi_cs)
    begin
        flash_bits = 0;
    end

    always @(posedge spi_clk)
    begin
        if (spi_cs === 1'b0 && flash_bits < 32)
        begin
            flash_instr = {flash_instr[30:0], spi_mosi}; // Opcode then address, MSB first
            flash_bits  = flash_bits + 1;
        end
    end

    always @(negedge spi_clk)
    begin : flash_shift_out
        int          bit_idx;
        logic [7:0]  data_byte;
        if (spi_cs === 1'b0 && flash_bits >= 32 && flash_instr[31:24] == `LOADER_READ_OPCODE)
        begin
            bit_idx    = flash_bits - 32;
            data_byte  = flash_byte(flash_instr[23:0] + 24'(bit_idx / 8));
            spi_miso   <= data_byte[7 - (bit_idx % 8)];
            flash_bits = flash_bits + 1;
        end
    end

    always @(negedge master_clock)
    begin
        if (rst_n && credit.valid === 1'b1)
        begin
            returned = returned + 1;
        end
    end

    task automatic wait_for_credit();
        int cycles;
        cycles = 0;
        while (issued - returned >= `LOADER_CREDITS && cycles < WAIT_LIMIT)
        begin
            @(posedge master_clock);
            cycles++;
        end
        if (issued - returned >= `LOADER_CREDITS)
        begin
            $display("Timed out after %0d cycles waiting for the loader to return a credit", cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_all_credits();
        int cycles;
        cycles = 0;
        while (returned < issued && cycles < WAIT_LIMIT)
        begin
            @(posedge master_clock);
            cycles++;
        end
        if (returned < issued)
        begin
            $display("Timed out with %0d credits still held by the loader", issued - returned);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_random_command();
        int pick;
        pick     = $unsigned($random(seed)) % 100;
        cmd      = '0;
        cmd.page = 12'($random(seed));
        if (pick < 15)
        begin
            cmd.kind = LOAD_BOOT; // Page bits left random
        end
        else if (pick < 30)
        begin
            cmd.kind = LOAD_PAGE;
            cmd.page = 12'(`LOADER_LAST_PAGE + 1 + $unsigned($random(seed)) % 12'h7fb);
        end
        else
        begin
            cmd.kind = LOAD_PAGE;
            cmd.page = 12'($unsigned($random(seed)) % (`LOADER_LAST_PAGE + 1));
        end
        cmd.valid = 1'b1;
        issued    = issued + 1;
        @(posedge master_clock);
        #10;
        cmd = '0;
    endtask

    initial
    begin : stimulus
        int gap;
        int sent;
        seed         = 68;
        rst_n        = 1'b0;
        cmd          = '0;
        spi_miso     = 1'b0;
        image_number = 3'($random(seed));
        sent         = 0;
        repeat (3) @(posedge master_clock);
        #10;
        rst_n = 1'b1;
        while (sent < NUM_COMMANDS && !timed_out)
        begin
            gap = $unsigned($random(seed)) % 12;
            repeat (gap) @(posedge master_clock);
            wait_for_credit();
            if (!timed_out)
            begin
                @(posedge master_clock);
                #10;
                send_random_command();
                sent++;
            end
        end
        if (!timed_out)
        begin
            wait_for_all_credits();
        end
        repeat (4) @(posedge master_clock);
        bubble_loader_checker_inst.finish_checks(error_count);
        if (!timed_out && error_count == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
